// ==== rx_pcs.f ====
hw/rx_pcs_pkg.sv
hw/block_lock.sv
hw/ber_monitor.sv
hw/status_regs.sv
hw/rx_pcs_top.sv
sim/clock_gen.sv
sim/tb_rx_pcs.sv

// ==== Makefile ====
SRCS := $(wildcard hw/*.sv sim/*.sv)

all: run

obj_dir/Vtb_rx_pcs: $(SRCS) rx_pcs.f
	verilator --binary --assert -Wno-fatal --top-module tb_rx_pcs -f rx_pcs.f -o Vtb_rx_pcs

run: obj_dir/Vtb_rx_pcs
	./obj_dir/Vtb_rx_pcs | tee /dev/stderr | grep -q "Everything OK"

clean:
	rm -rf obj_dir

.PHONY: all run clean

// ==== sim/tb_rx_pcs.sv ====
// rx pcs testbench with directed lock, hi-BER, lock loss, clear-on-read and signal loss tests
`timescale 1ns/1ps

module tb_rx_pcs;

    localparam int NL            = rx_pcs_pkg::N_LANES;
    localparam int RELOCK_BLOCKS = 66 * 64 + 64;
    localparam int BER_WIN       = rx_pcs_pkg::BER_WINDOW_BLOCKS;
    localparam longint WATCHDOG_NS = 2 * (5 * RELOCK_BLOCKS + 8 * BER_WIN) * 40;

    logic                                    clock;
    logic                                    reset;
    logic                                    i_enable;
    logic                                    i_signal_ok;
    logic                                    i_valid;
    rx_pcs_pkg::block_t [NL-1:0]             i_data;
    rx_pcs_pkg::lock_cfg_t                   i_cfg;
    logic                                    i_read_status;
    rx_pcs_pkg::block_t [NL-1:0]             o_data;
    logic [NL-1:0]                           o_valid;
    logic [NL-1:0]                           o_block_lock;
    logic [NL-1:0]                           o_hi_ber;
    rx_pcs_pkg::lane_status_t [NL-1:0]       o_status;

    logic [31:0]        lfsr = 32'hdd60_b238;
    rx_pcs_pkg::block_t prev_block [NL];
    rx_pcs_pkg::block_t ring [NL][16];    // recent sent blocks per lane
    int                 blk_num = 0;
    int                 lane_offset [NL] = '{0, 1, 33, 65};
    int                 errors = 0;
    int                 tests_passed = 0;
    int                 tests_failed = 0;

    clock_gen u_clock_gen (.o_clock(clock), .o_reset(reset));

    rx_pcs_top u_rx_pcs_top
    (
        .i_clock(clock), .i_reset(reset), .i_enable(i_enable), .i_signal_ok(i_signal_ok),
        .i_valid(i_valid), .i_data(i_data), .i_cfg(i_cfg), .i_read_status(i_read_status),
        .o_data(o_data), .o_valid(o_valid), .o_block_lock(o_block_lock),
        .o_hi_ber(o_hi_ber), .o_status(o_status)
    );

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic next_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic rx_pcs_pkg::block_t make_block(input logic bad);
        logic [63:0] payload;
        logic        h;
        for (int i = 0; i < 64; i++)
            payload[i] = next_bit();
        h = next_bit();
        return bad ? {payload, h, h} : {payload, h, ~h};   // 00/11 invalid
    endfunction

    // one valid word per lane cut from the serial stream at the lane offset
    task automatic send_cycle(input logic [NL-1:0] bad);
        rx_pcs_pkg::block_t              blk;
        logic [2*rx_pcs_pkg::NB_BLOCK-1:0] pair;
        @(negedge clock);
        for (int l = 0; l < NL; l++)
        begin
            blk  = make_block(bad[l]);
            pair = {blk, prev_block[l]};
            i_data[l] = pair[66 - lane_offset[l] +: 66];
            prev_block[l] = blk;
            ring[l][blk_num % 16] = blk;
        end
        i_valid = 1'b1;
        blk_num++;
    endtask

    task automatic wait_lock(input logic [NL-1:0] mask);
        int n;
        n = 0;
        while ((o_block_lock & mask) != mask && n < RELOCK_BLOCKS)
        begin
            send_cycle('0);
            n++;
        end
        if ((o_block_lock & mask) != mask)
        begin
            $display("lanes %b did not lock within %0d blocks at %0t", mask, n, $time);
            errors++;
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("FAILED t=%0t %s got %0h exp %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        if (errors == err_before)
        begin
            $display("test %s: pass", name);
            tests_passed++;
        end
        else
        begin
            $display("test %s: fail", name);
            tests_failed++;
        end
    endtask

    task automatic after_reset();
        int e;
        e = errors;
        check_value("o_valid", o_valid, 0);
        check_value("o_block_lock", o_block_lock, 0);
        check_value("o_hi_ber", o_hi_ber, 0);
        check_value("o_status", o_status, 0);
        end_test("reset", e);
    endtask

    task automatic acquire_lock();
        int e;
        int idx [NL];
        logic found;
        e = errors;
        wait_lock('1);
        send_cycle('0);
        for (int l = 0; l < NL; l++)
        begin
            found = 1'b0;
            for (int j = blk_num - 1; j >= blk_num - 8; j--)
                if (!found && ring[l][j % 16] == o_data[l])
                begin
                    found  = 1'b1;
                    idx[l] = j;
                end
            if (!found)
            begin
                $display("lane %0d output block not found among sent blocks", l);
                errors++;
                idx[l] = blk_num - 2;
            end
        end
        repeat (100)
        begin
            send_cycle('0);
            for (int l = 0; l < NL; l++)
            begin
                idx[l]++;
                if (o_data[l] !== ring[l][idx[l] % 16])
                begin
                    $display("FAILED t=%0t o_data[%0d] got %h exp %h",
                             $time, l, o_data[l], ring[l][idx[l] % 16]);
                    errors++;
                end
                check_value($sformatf("o_valid[%0d]", l), o_valid[l], 1);
            end
        end
        end_test("lock", e);
    endtask

    task automatic raise_hi_ber();
        int e;
        int n;
        e = errors;
        i_cfg.sh_invalid_limit = 8'd255;
        n = 0;
        for (int i = 0; i < 80; i++)
        begin
            send_cycle({3'b000, i[0] == 1'b0});   // every other block bad on lane 0
            n++;
        end
        while (!o_hi_ber[0] && n < 2 * BER_WIN)
        begin
            send_cycle('0);
            n++;
        end
        check_value("o_hi_ber[0]", o_hi_ber[0], 1);
        check_value("o_hi_ber[3:1]", o_hi_ber[3:1], 0);
        n = 0;
        while (o_hi_ber[0] && n < 2 * BER_WIN)
        begin
            send_cycle('0);
            n++;
        end
        check_value("o_hi_ber", o_hi_ber, 0);
        check_value("o_block_lock", o_block_lock, 4'hf);
        check_value("o_status[0].hi_ber_seen", o_status[0].hi_ber_seen, 1);
        i_cfg.sh_invalid_limit = 8'd16;
        end_test("hi_ber", e);
    endtask

    // invalid headers on one lane until it drops lock or 40 are sent
    task automatic force_loss(input int lane);
        int n;
        n = 0;
        while (o_block_lock[lane] && n < 40)
        begin
            send_cycle(4'b0001 << lane);
            n++;
        end
        if (o_block_lock[lane])
        begin
            $display("lane %0d kept lock through %0d invalid headers", lane, n);
            errors++;
        end
        send_cycle('0);
    endtask

    task automatic lose_and_relock();
        int e;
        e = errors;
        force_loss(1);
        check_value("o_status[1].lock_lost", o_status[1].lock_lost, 1);
        check_value("o_status[1].loss_count", o_status[1].loss_count, 1);
        wait_lock('1);
        send_cycle('0);
        check_value("o_status[1].loss_count", o_status[1].loss_count, 1);
        end_test("lock_loss", e);
    endtask

    task automatic clear_on_read();
        int e;
        e = errors;
        i_read_status = 1'b1;
        send_cycle('0);
        check_value("o_status", o_status, 0);
        force_loss(2);
        wait_lock('1);
        // strobe still high, the loss must not be cleared again
        check_value("o_status[2].lock_lost", o_status[2].lock_lost, 1);
        check_value("o_status[2].loss_count", o_status[2].loss_count, 1);
        i_read_status = 1'b0;
        end_test("clear_on_read", e);
    endtask

    task automatic drop_signal();
        int e;
        e = errors;
        i_signal_ok = 1'b0;
        send_cycle('0);
        i_signal_ok = 1'b1;
        check_value("o_block_lock", o_block_lock, 0);
        send_cycle('0);
        for (int l = 0; l < NL; l++)
        begin
            check_value($sformatf("o_status[%0d].lock_lost", l), o_status[l].lock_lost, 1);
            // lane 2 also lost lock during the read test
            check_value($sformatf("o_status[%0d].loss_count", l), o_status[l].loss_count,
                        (l == 2) ? 2 : 1);
        end
        wait_lock('1);
        end_test("signal_loss", e);
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Something failed");
        $finish;
    end

    initial
    begin
        i_enable      = 1'b1;
        i_signal_ok   = 1'b1;
        i_valid       = 1'b0;
        i_data        = '0;
        i_read_status = 1'b0;
        i_cfg.unlocked_timer_limit = 10'd64;
        i_cfg.locked_timer_limit   = 10'd128;
        i_cfg.sh_invalid_limit     = 8'd16;
        for (int l = 0; l < NL; l++)
            prev_block[l] = '0;
        wait (reset == 1'b0);
        @(negedge clock);
        after_reset();
        acquire_lock();
        raise_hi_ber();
        lose_and_relock();
        clear_on_read();
        drop_signal();
        $display("tests passed %0d failed %0d, %0d check errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// ==== sim/clock_gen.sv ====
// clock generator for the 40 ns testbench clock and a reset held for 4 cycles
`timescale 1ns/1ps

module clock_gen
(
    output logic o_clock,
    output logic o_reset
);

    initial
    begin
        o_clock = 1'b0;
        forever #20 o_clock = ~o_clock;
    end

    initial
    begin
        o_reset = 1'b1;
        repeat (4) @(posedge o_clock);
        @(negedge o_clock);
        o_reset = 1'b0;   // released on a falling edge
    end

endmodule

// ==== hw/rx_pcs_top.sv ====
// rx pcs top with per-lane block lock and ber monitor and shared status registers
`timescale 1ns/1ps

module rx_pcs_top
(
    input  logic                                                 i_clock,
    input  logic                                                 i_reset,
    input  logic                                                 i_enable,
    input  logic                                                 i_signal_ok,
    input  logic                                                 i_valid,
    input  rx_pcs_pkg::block_t [rx_pcs_pkg::N_LANES-1:0]         i_data,
    input  rx_pcs_pkg::lock_cfg_t                                i_cfg,
    input  logic                                                 i_read_status,
    output rx_pcs_pkg::block_t [rx_pcs_pkg::N_LANES-1:0]         o_data,
    output logic [rx_pcs_pkg::N_LANES-1:0]                       o_valid,
    output logic [rx_pcs_pkg::N_LANES-1:0]                       o_block_lock,
    output logic [rx_pcs_pkg::N_LANES-1:0]                       o_hi_ber,
    output rx_pcs_pkg::lane_status_t [rx_pcs_pkg::N_LANES-1:0]   o_status
);

    logic [rx_pcs_pkg::N_LANES-1:0] lane_locked;
    logic [rx_pcs_pkg::N_LANES-1:0] sh_check;
    logic [rx_pcs_pkg::N_LANES-1:0] sh_invalid;
    logic [rx_pcs_pkg::N_LANES-1:0] hi_ber;

    for (genvar l = 0; l < rx_pcs_pkg::N_LANES; l++)
    begin : g_lane
        block_lock u_block_lock
        (
            .i_clock      (i_clock),
            .i_reset      (i_reset),
            .i_enable     (i_enable),
            .i_signal_ok  (i_signal_ok),
            .i_valid      (i_valid),
            .i_data       (i_data[l]),
            .i_cfg        (i_cfg),
            .o_data       (o_data[l]),
            .o_valid      (o_valid[l]),
            .o_locked     (lane_locked[l]),
            .o_sh_check   (sh_check[l]),
            .o_sh_invalid (sh_invalid[l])
        );

        ber_monitor u_ber_monitor
        (
            .i_clock      (i_clock),
            .i_reset      (i_reset),
            .i_locked     (lane_locked[l]),
            .i_sh_check   (sh_check[l]),
            .i_sh_invalid (sh_invalid[l]),
            .o_hi_ber     (hi_ber[l])
        );
    end

    status_regs u_status_regs
    (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_read_status (i_read_status),
        .i_locked      (lane_locked),
        .i_hi_ber      (hi_ber),
        .o_status      (o_status)
    );

    assign o_block_lock = lane_locked;   // live levels
    assign o_hi_ber     = hi_ber;

endmodule

// ==== hw/status_regs.sv ====
// status registers with read edge detect and clear-on-read sticky lane status
`timescale 1ns/1ps

module status_regs
(
    input  logic                                                 i_clock,
    input  logic                                                 i_reset,
    input  logic                                                 i_read_status,
    input  logic [rx_pcs_pkg::N_LANES-1:0]                       i_locked,
    input  logic [rx_pcs_pkg::N_LANES-1:0]                       i_hi_ber,
    output rx_pcs_pkg::lane_status_t [rx_pcs_pkg::N_LANES-1:0]   o_status
);

    logic                                               read_d;
    logic                                               read_rise;
    logic [rx_pcs_pkg::N_LANES-1:0]                     locked_d;
    logic [rx_pcs_pkg::N_LANES-1:0]                     lock_fall;
    rx_pcs_pkg::lane_status_t [rx_pcs_pkg::N_LANES-1:0] status_next;

    assign read_rise = i_read_status & ~read_d;
    assign lock_fall = locked_d & ~i_locked;

    always_comb
    begin
        for (int l = 0; l < rx_pcs_pkg::N_LANES; l++)
        begin
            status_next[l] = read_rise ? '0 : o_status[l];
            // an event on the read edge still lands
            if (lock_fall[l])
            begin
                status_next[l].lock_lost = 1'b1;
                if (status_next[l].loss_count != '1)
                    status_next[l].loss_count = status_next[l].loss_count + 1'b1;
            end
            if (i_hi_ber[l])
                status_next[l].hi_ber_seen = 1'b1;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            read_d   <= 1'b0;
            locked_d <= '0;
            o_status <= '0;
        end
        else
        begin
            read_d   <= i_read_status;
            locked_d <= i_locked;
            o_status <= status_next;
        end
    end

    for (genvar l = 0; l < rx_pcs_pkg::N_LANES; l++)
    begin : g_lane_check
        a_loss_no_wrap: assert property (@(posedge i_clock) disable iff (i_reset)
            (o_status[l].loss_count == '1 && !read_rise) |=> o_status[l].loss_count == '1);
    end

endmodule

// ==== hw/ber_monitor.sv ====
// ber monitor that counts invalid sync headers per window and raises hi-BER for one lane
`timescale 1ns/1ps

module ber_monitor
(
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_locked,
    input  logic i_sh_check,
    input  logic i_sh_invalid,
    output logic o_hi_ber
);

    logic [rx_pcs_pkg::NB_BER_WINDOW-1:0] blk_cnt;
    logic [rx_pcs_pkg::NB_BER_INV-1:0]    inv_cnt;
    logic [rx_pcs_pkg::NB_BER_INV-1:0]    inv_cnt_next;
    logic                                 window_end;

    assign window_end = (blk_cnt == rx_pcs_pkg::BER_WINDOW_BLOCKS - 1);

    // saturates at the limit
    assign inv_cnt_next = (i_sh_invalid && inv_cnt != rx_pcs_pkg::HI_BER_LIMIT) ?
                          inv_cnt + 1'b1 : inv_cnt;

    always_ff @(posedge i_clock)
    begin
        if (i_reset || !i_locked)
        begin
            blk_cnt  <= '0;
            inv_cnt  <= '0;
            o_hi_ber <= 1'b0;
        end
        else if (i_sh_check)
        begin
            if (window_end)
            begin
                blk_cnt  <= '0;
                inv_cnt  <= '0;
                o_hi_ber <= (inv_cnt_next >= rx_pcs_pkg::HI_BER_LIMIT);
            end
            else
            begin
                blk_cnt <= blk_cnt + 1'b1;
                inv_cnt <= inv_cnt_next;
            end
        end
    end

    a_no_hi_ber_unlocked: assert property (@(posedge i_clock) disable iff (i_reset)
        !i_locked |=> !o_hi_ber);

endmodule

// ==== hw/block_lock.sv ====
// block lock with bit-slip aligner and sync-header lock FSM for one lane
`timescale 1ns/1ps

module block_lock
(
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_enable,
    input  logic                  i_signal_ok,
    input  logic                  i_valid,
    input  rx_pcs_pkg::block_t    i_data,
    input  rx_pcs_pkg::lock_cfg_t i_cfg,
    output rx_pcs_pkg::block_t    o_data,
    output logic                  o_valid,
    output logic                  o_locked,
    output logic                  o_sh_check,
    output logic                  o_sh_invalid
);

    rx_pcs_pkg::block_t                   data_prev;
    logic [2*rx_pcs_pkg::NB_BLOCK-1:0]    data_pair;
    rx_pcs_pkg::block_t                   window;
    logic [rx_pcs_pkg::NB_SH-1:0]         sh;
    logic                                 sh_valid;
    logic                                 run;
    rx_pcs_pkg::lock_state_e              state;
    logic [rx_pcs_pkg::NB_OFFSET-1:0]     offset;
    logic [rx_pcs_pkg::NB_OFFSET-1:0]     offset_slip;
    logic [rx_pcs_pkg::NB_WINDOW_CNT-1:0] sh_cnt;
    logic [rx_pcs_pkg::NB_WINDOW_CNT-1:0] sh_cnt_next;
    logic [rx_pcs_pkg::NB_INV_SH-1:0]     inv_cnt;
    logic [rx_pcs_pkg::NB_INV_SH-1:0]     inv_cnt_next;

    // older word in the low half since bit 0 arrives first
    assign data_pair = {i_data, data_prev};
    assign window    = data_pair[offset +: rx_pcs_pkg::NB_BLOCK];
    assign sh        = window[rx_pcs_pkg::NB_SH-1:0];
    assign sh_valid  = (sh == rx_pcs_pkg::SH_DATA) || (sh == rx_pcs_pkg::SH_CTRL);
    assign run       = i_enable & i_signal_ok;

    assign offset_slip  = (offset == rx_pcs_pkg::NB_BLOCK - 1) ? '0 : offset + 1'b1;
    assign sh_cnt_next  = sh_cnt + 1'b1;
    assign inv_cnt_next = sh_valid ? inv_cnt : inv_cnt + 1'b1;

    assign o_locked = (state == rx_pcs_pkg::st_locked);

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            data_prev <= '0;
            o_data    <= '0;
        end
        else if (i_valid)
        begin
            data_prev <= i_data;
            o_data    <= window;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_valid      <= 1'b0;
            o_sh_check   <= 1'b0;
            o_sh_invalid <= 1'b0;
        end
        else
        begin
            o_valid      <= i_valid;
            o_sh_check   <= i_valid & run;
            o_sh_invalid <= i_valid & run & ~sh_valid;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            state   <= rx_pcs_pkg::st_hunt;
            offset  <= '0;
            sh_cnt  <= '0;
            inv_cnt <= '0;
        end
        else if (!run)
        begin
            state   <= rx_pcs_pkg::st_hunt;   // offset kept for a quick relock
            sh_cnt  <= '0;
            inv_cnt <= '0;
        end
        else if (i_valid)
        begin
            case (state)
                rx_pcs_pkg::st_hunt, rx_pcs_pkg::st_test:
                begin
                    if (!sh_valid)
                    begin
                        state  <= rx_pcs_pkg::st_hunt;
                        sh_cnt <= '0;
                        offset <= offset_slip;
                    end
                    else if (sh_cnt_next == i_cfg.unlocked_timer_limit)
                    begin
                        state   <= rx_pcs_pkg::st_locked;
                        sh_cnt  <= '0;
                        inv_cnt <= '0;
                    end
                    else
                    begin
                        state  <= rx_pcs_pkg::st_test;
                        sh_cnt <= sh_cnt_next;
                    end
                end
                rx_pcs_pkg::st_locked:
                begin
                    if (!sh_valid && inv_cnt_next == i_cfg.sh_invalid_limit)
                    begin
                        state   <= rx_pcs_pkg::st_hunt;
                        sh_cnt  <= '0;
                        inv_cnt <= '0;
                        offset  <= offset_slip;
                    end
                    else if (sh_cnt_next == i_cfg.locked_timer_limit)
                    begin
                        sh_cnt  <= '0;   // window end
                        inv_cnt <= '0;
                    end
                    else
                    begin
                        sh_cnt  <= sh_cnt_next;
                        inv_cnt <= inv_cnt_next;
                    end
                end
                default: state <= rx_pcs_pkg::st_hunt;
            endcase
        end
    end

    a_offset_range: assert property (@(posedge i_clock) disable iff (i_reset)
        offset < rx_pcs_pkg::NB_BLOCK);

    a_valid_follows: assert property (@(posedge i_clock) disable iff (i_reset)
        !i_valid |=> !o_valid);

endmodule

// ==== hw/rx_pcs_pkg.sv ====
// rx pcs package with widths, limits, block type, lock config and lane status types
package rx_pcs_pkg;

    localparam int N_LANES           = 4;
    localparam int NB_BLOCK          = 66;
    localparam int NB_SH             = 2;
    localparam int NB_OFFSET         = 7;   // slip offset 0..65
    localparam int NB_WINDOW_CNT     = 10;
    localparam int NB_INV_SH         = 8;
    localparam int NB_LOSS_CNT       = 8;

    // sync header codes at the low end of the block
    localparam logic [NB_SH-1:0] SH_DATA = 2'b01;
    localparam logic [NB_SH-1:0] SH_CTRL = 2'b10;

    // ber monitor window
    localparam int BER_WINDOW_BLOCKS = 256;
    localparam int HI_BER_LIMIT      = 16;
    localparam int NB_BER_WINDOW     = $clog2(BER_WINDOW_BLOCKS);
    localparam int NB_BER_INV        = $clog2(HI_BER_LIMIT + 1);

    typedef logic [NB_BLOCK-1:0] block_t;

    typedef enum logic [1:0] {
        st_hunt,
        st_test,
        st_locked
    } lock_state_e;

    typedef struct packed {
        logic [NB_WINDOW_CNT-1:0] unlocked_timer_limit;
        logic [NB_WINDOW_CNT-1:0] locked_timer_limit;
        logic [NB_INV_SH-1:0]     sh_invalid_limit;
    } lock_cfg_t;

    typedef struct packed {
        logic                   lock_lost;     // sticky until read
        logic                   hi_ber_seen;   // sticky until read
        logic [NB_LOSS_CNT-1:0] loss_count;    // saturating
    } lane_status_t;

endpackage
